//--- Bender.yml
package:
  name: afifo

sources:
  - hdl/afifo_cfg_pkg.sv
  - hdl/afifo_reg_pkg.sv
  - hdl/afifo_wr_ptr.sv
  - hdl/afifo_rd_ptr.sv
  - hdl/afifo_ram.sv
  - hdl/afifo_level_regs.sv
  - hdl/afifo_top.sv
  - target: test
    files:
      - test/afifo_tb.sv

//--- hdl/afifo_cfg_pkg.sv
package afifo_cfg_pkg;

    // ====================
    // RAM geometry
    // ====================

    // Capacity of the block RAM, fixed for every word width
    localparam int ram_bits = 4096;

    // Widest RAM address, reached at W of 2 (2048 words)
    localparam int max_addr_bits = 11;

    // Address plus wrap bit
    localparam int ptr_bits = max_addr_bits + 1;

    // Fill level must reach a full depth, so one bit over the address
    localparam int level_bits = max_addr_bits + 1;

    // ====================
    // Pointer
    // ====================

    // Binary and gray forms of one FIFO pointer.
    // Narrower FIFOs use the low bits only, the rest stay zero.
    typedef struct packed {
        logic [ptr_bits-1:0] bin;   // Binary count, MSB is the wrap bit
        logic [ptr_bits-1:0] gray;  // Gray form, safe to cross domains
    } ptr_t;

endpackage

//--- hdl/afifo_level_regs.sv
module afifo_level_regs (
    input  logic                                  r_clk,
    input  logic                                  rst_,
    input  afifo_reg_pkg::reg_req_t               reg_req,
    input  logic [afifo_cfg_pkg::level_bits-1:0]  fill_level,
    input  logic                                  pop_when_empty,
    output afifo_reg_pkg::reg_rsp_t               reg_rsp,
    output logic                                  level_alert
);

    localparam int dw = afifo_reg_pkg::reg_data_bits;

    logic [dw-1:0] thresh_q;
    logic          underrun_q;  // Sticky
    logic          thresh_wr;
    logic          status_wr;

    assign thresh_wr = reg_req.wr && (reg_req.addr == afifo_reg_pkg::reg_thresh);
    assign status_wr = reg_req.wr && (reg_req.addr == afifo_reg_pkg::reg_status);

    // ====================
    // Registers
    // ====================
    always_ff @(posedge r_clk or negedge rst_) begin
        if (!rst_) begin
            thresh_q    <= '0;
            underrun_q  <= 1'b0;
            level_alert <= 1'b0;
        end else begin
            if (thresh_wr) begin
                thresh_q <= reg_req.wdata;
            end

            // New underrun beats a clear in the same cycle
            if (pop_when_empty) begin
                underrun_q <= 1'b1;
            end else if (status_wr) begin
                underrun_q <= 1'b0;
            end

            level_alert <= (fill_level < thresh_q);  // Low-level alert
        end
    end

    // ====================
    // Read decode
    // ====================
    always_comb begin
        case (reg_req.addr)
            afifo_reg_pkg::reg_thresh: reg_rsp.rdata = thresh_q;
            afifo_reg_pkg::reg_level:  reg_rsp.rdata = fill_level;
            afifo_reg_pkg::reg_status: reg_rsp.rdata = {{(dw-1){1'b0}}, underrun_q};
            default:                   reg_rsp.rdata = '0;  // Unmapped
        endcase
    end

endmodule

//--- hdl/afifo_ram.sv
module afifo_ram #(
    parameter int W = 8
) (
    input  logic                                     w_clk,
    input  logic                                     w_en,
    input  logic [afifo_cfg_pkg::max_addr_bits-1:0]  w_addr,
    input  logic [W-1:0]                             w_data,
    input  logic                                     r_clk,
    input  logic [afifo_cfg_pkg::max_addr_bits-1:0]  r_addr,
    output logic [W-1:0]                             r_data
);

    localparam int depth = afifo_cfg_pkg::ram_bits / W;
    localparam int aw    = $clog2(depth);

    // Storage only, no reset
    logic [W-1:0] mem [depth];

    // ====================
    // Write port
    // ====================
    always_ff @(posedge w_clk) begin
        if (w_en) begin
            mem[w_addr[aw-1:0]] <= w_data;
        end
    end

    // ====================
    // Read port
    // ====================

    // Reads every cycle, address already points at the next head
    always_ff @(posedge r_clk) begin
        r_data <= mem[r_addr[aw-1:0]];
    end

endmodule

//--- hdl/afifo_rd_ptr.sv
module afifo_rd_ptr #(
    parameter int W = 8
) (
    input  logic                                     r_clk,
    input  logic                                     rst_,
    input  logic                                     r_trigger,
    input  logic [afifo_cfg_pkg::ptr_bits-1:0]       wr_gray,       // From w_clk domain
    output afifo_cfg_pkg::ptr_t                      rd_ptr,
    output logic [afifo_cfg_pkg::max_addr_bits-1:0]  rd_addr_next,  // RAM read address
    output logic                                     r_ready,
    output logic [afifo_cfg_pkg::level_bits-1:0]     fill_level,
    output logic                                     pop_when_empty
);

    localparam int depth = afifo_cfg_pkg::ram_bits / W;
    localparam int aw    = $clog2(depth);
    localparam int pw    = afifo_cfg_pkg::ptr_bits;
    localparam int ma    = afifo_cfg_pkg::max_addr_bits;
    localparam int lw    = afifo_cfg_pkg::level_bits;

    logic [aw:0] bin_q;
    logic [aw:0] gray_q;
    logic [aw:0] bin_next;
    logic [aw:0] gray_next;
    logic [aw:0] wr_gray_meta;
    logic [aw:0] wr_gray_sync;
    logic [aw:0] wr_bin_sync;   // Synced write pointer, decoded
    logic [aw:0] level_diff;    // Modulo the pointer width
    logic        pop;
    logic [lw-1:0] level_q;

    function automatic logic [aw:0] gray2bin(input logic [aw:0] g);
        logic [aw:0] b;
        b[aw] = g[aw];
        for (int i = aw - 1; i >= 0; i--) begin
            b[i] = b[i+1] ^ g[i];
        end
        return b;
    endfunction

    assign pop            = r_trigger && r_ready;
    assign pop_when_empty = r_trigger && !r_ready;  // Ignored pop

    assign bin_next  = bin_q + {{aw{1'b0}}, pop};
    assign gray_next = (bin_next >> 1) ^ bin_next;

    assign wr_bin_sync = gray2bin(wr_gray_sync);
    assign level_diff  = wr_bin_sync - bin_q;

    // ====================
    // Pointer, sync, level
    // ====================
    always_ff @(posedge r_clk or negedge rst_) begin
        if (!rst_) begin
            bin_q        <= '0;
            gray_q       <= '0;
            wr_gray_meta <= '0;
            wr_gray_sync <= '0;
            r_ready      <= 1'b0;
            level_q      <= '0;
        end else begin
            bin_q        <= bin_next;
            gray_q       <= gray_next;
            wr_gray_meta <= wr_gray[aw:0];
            wr_gray_sync <= wr_gray_meta;
            r_ready      <= (gray_next != wr_gray_sync);  // Not empty
            // Lags writes, never overstates
            level_q      <= lw'(level_diff);
        end
    end

    assign fill_level = level_q;

    // Next pointer feeds the RAM so r_data tracks the head
    assign rd_addr_next = ma'(bin_next[aw-1:0]);

    assign rd_ptr.bin  = pw'(bin_q);
    assign rd_ptr.gray = pw'(gray_q);

endmodule

//--- hdl/afifo_reg_pkg.sv
package afifo_reg_pkg;

    // ====================
    // Register map
    // ====================

    localparam int reg_data_bits = 12;

    typedef enum logic [1:0] {
        reg_thresh = 2'd0,  // Low-level threshold, read/write
        reg_level  = 2'd1,  // Current fill level, read only
        reg_status = 2'd2   // Bit 0 underrun, write clears
    } reg_addr_e;

    // ====================
    // Access structs
    // ====================

    // Request from the host, r_clk domain
    typedef struct packed {
        logic                     wr;     // Write strobe
        reg_addr_e                addr;
        logic [reg_data_bits-1:0] wdata;
    } reg_req_t;

    // Read data, combinational from the request address
    typedef struct packed {
        logic [reg_data_bits-1:0] rdata;
    } reg_rsp_t;

endpackage

//--- hdl/afifo_top.sv
module afifo_top #(
    parameter int W = 8     // 16, 8, 4 or 2
) (
    input  logic                     rst_,

    // Write side
    input  logic                     w_clk,
    input  logic                     w_trigger,
    input  logic [W-1:0]             w_data,
    output logic                     w_ready,

    // Read side
    input  logic                     r_clk,
    input  logic                     r_trigger,
    output logic [W-1:0]             r_data,
    output logic                     r_ready,

    // Registers, r_clk domain
    input  afifo_reg_pkg::reg_req_t  reg_req,
    output afifo_reg_pkg::reg_rsp_t  reg_rsp,
    output logic                     level_alert
);

    afifo_cfg_pkg::ptr_t                          wr_ptr;
    afifo_cfg_pkg::ptr_t                          rd_ptr;
    logic                                         w_en;
    logic [afifo_cfg_pkg::max_addr_bits-1:0]      rd_addr_next;
    logic [afifo_cfg_pkg::level_bits-1:0]         fill_level;
    logic                                         pop_when_empty;

    afifo_wr_ptr #(.W(W)) afifo_wr_ptr_i (
        .w_clk     (w_clk),
        .rst_      (rst_),
        .w_trigger (w_trigger),
        .rd_gray   (rd_ptr.gray),
        .wr_ptr    (wr_ptr),
        .w_ready   (w_ready),
        .w_en      (w_en)
    );

    afifo_rd_ptr #(.W(W)) afifo_rd_ptr_i (
        .r_clk          (r_clk),
        .rst_           (rst_),
        .r_trigger      (r_trigger),
        .wr_gray        (wr_ptr.gray),
        .rd_ptr         (rd_ptr),
        .rd_addr_next   (rd_addr_next),
        .r_ready        (r_ready),
        .fill_level     (fill_level),
        .pop_when_empty (pop_when_empty)
    );

    afifo_ram #(.W(W)) afifo_ram_i (
        .w_clk  (w_clk),
        .w_en   (w_en),
        .w_addr (wr_ptr.bin[afifo_cfg_pkg::max_addr_bits-1:0]),  // Wrap bit dropped
        .w_data (w_data),
        .r_clk  (r_clk),
        .r_addr (rd_addr_next),
        .r_data (r_data)
    );

    afifo_level_regs afifo_level_regs_i (
        .r_clk          (r_clk),
        .rst_           (rst_),
        .reg_req        (reg_req),
        .fill_level     (fill_level),
        .pop_when_empty (pop_when_empty),
        .reg_rsp        (reg_rsp),
        .level_alert    (level_alert)
    );

endmodule

//--- hdl/afifo_wr_ptr.sv
module afifo_wr_ptr #(
    parameter int W = 8
) (
    input  logic                                   w_clk,
    input  logic                                   rst_,
    input  logic                                   w_trigger,
    input  logic [afifo_cfg_pkg::ptr_bits-1:0]     rd_gray,   // From r_clk domain
    output afifo_cfg_pkg::ptr_t                    wr_ptr,
    output logic                                   w_ready,
    output logic                                   w_en
);

    localparam int depth = afifo_cfg_pkg::ram_bits / W;
    localparam int aw    = $clog2(depth);
    localparam int pw    = afifo_cfg_pkg::ptr_bits;

    logic [aw:0] bin_q;
    logic [aw:0] gray_q;
    logic [aw:0] bin_next;
    logic [aw:0] gray_next;
    logic [aw:0] rd_gray_meta;  // First sync stage
    logic [aw:0] rd_gray_sync;
    logic        full;

    // Accepted write, also the RAM write enable
    assign w_en = w_trigger && !full;

    assign bin_next  = bin_q + {{aw{1'b0}}, w_en};
    assign gray_next = (bin_next >> 1) ^ bin_next;

    // ====================
    // Pointer and sync
    // ====================
    always_ff @(posedge w_clk or negedge rst_) begin
        if (!rst_) begin
            bin_q        <= '0;
            gray_q       <= '0;
            rd_gray_meta <= '0;
            rd_gray_sync <= '0;
            full         <= 1'b0;
        end else begin
            bin_q        <= bin_next;
            gray_q       <= gray_next;
            rd_gray_meta <= rd_gray[aw:0];
            rd_gray_sync <= rd_gray_meta;
            // Full when one lap ahead of the reader
            full <= (gray_next == {~rd_gray_sync[aw:aw-1], rd_gray_sync[aw-2:0]});
        end
    end

    assign w_ready = !full;

    // Zero-extend into the shared pointer struct
    assign wr_ptr.bin  = pw'(bin_q);
    assign wr_ptr.gray = pw'(gray_q);

endmodule

//--- project.f
hdl/afifo_cfg_pkg.sv
hdl/afifo_reg_pkg.sv
hdl/afifo_wr_ptr.sv
hdl/afifo_rd_ptr.sv
hdl/afifo_ram.sv
hdl/afifo_level_regs.sv
hdl/afifo_top.sv
test/afifo_tb.sv

//--- test/afifo_tb.sv
module afifo_tb;

    localparam int W          = 8;
    localparam int depth      = 4096 / W;   // 512 words
    localparam int wait_limit = 2000;

    logic                    r_clk;
    logic                    w_clk;
    logic                    rst_;
    logic                    w_trigger;
    logic                    r_trigger;
    logic [W-1:0]            w_data;
    logic [W-1:0]            r_data;
    logic                    w_ready;
    logic                    r_ready;
    logic                    level_alert;
    afifo_reg_pkg::reg_req_t reg_req;
    afifo_reg_pkg::reg_rsp_t reg_rsp;

    logic [W-1:0] ref_q[$];     // Words written but not yet read
    logic [W-1:0] head_word;
    int           wr_count;
    int           rd_count;
    int           n_pass;
    int           n_fail;
    int           fails_at_start;
    string        test_name;
    integer       seed;

    afifo_top #(.W(W)) afifo_top_i (
        .rst_        (rst_),
        .w_clk       (w_clk),
        .w_trigger   (w_trigger),
        .w_data      (w_data),
        .w_ready     (w_ready),
        .r_clk       (r_clk),
        .r_trigger   (r_trigger),
        .r_data      (r_data),
        .r_ready     (r_ready),
        .reg_req     (reg_req),
        .reg_rsp     (reg_rsp),
        .level_alert (level_alert)
    );

    // Settled fill level, every accepted write minus every accepted read
    function automatic int expected_level(input int writes, input int reads);
        return writes - reads;
    endfunction

    // ====================
    // Clocks
    // ====================
    initial begin
        r_clk = 1'b0;
        forever #5 r_clk = ~r_clk;
    end

    initial begin
        w_clk = 1'b0;
        forever #7 w_clk = ~w_clk;
    end

    // ====================
    // Reference and compare
    // ====================
    always @(posedge w_clk) begin
        if (rst_ && w_trigger && w_ready) begin
            ref_q.push_back(w_data);
            wr_count++;
        end
    end

    always @(posedge r_clk) begin
        if (rst_ && r_trigger && r_ready) begin
            rd_count++;
            assert (ref_q.size() > 0) else begin
                n_fail++;
                $display("A read was accepted with no word expected, at time %0t", $time);
            end
            if (ref_q.size() > 0) begin
                head_word = ref_q.pop_front();
                assert (r_data === head_word) n_pass++;
                else begin
                    n_fail++;
                    $display("[ERROR] %0t: r_data is %0h, expected %0h",
                             $time, r_data, head_word);
                end
            end
        end
    end

    // ====================
    // Helpers
    // ====================
    task automatic check_value(input int got, input int exp, input string what);
        assert (got == exp) n_pass++;
        else begin
            n_fail++;
            $display("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic abort_run(input string reason);
        $display("Run stopped, %s", reason);
        $display("checks passed: %0d, checks failed: %0d", n_pass, n_fail + 1);
        $display("Test failed");
        $finish;
    endtask

    task automatic begin_test(input string name);
        test_name      = name;
        fails_at_start = n_fail;
    endtask

    task automatic end_test;
        $display("%s: finished with %0d errors", test_name, n_fail - fails_at_start);
    endtask

    task automatic wait_w_ready(input logic level);
        int n;
        n = 0;
        while (w_ready !== level) begin
            if (n == wait_limit) abort_run("w_ready never reached the expected level");
            n++;
            @(negedge w_clk);
        end
    endtask

    task automatic wait_r_ready(input logic level);
        int n;
        n = 0;
        while (r_ready !== level) begin
            if (n == wait_limit) abort_run("r_ready never reached the expected level");
            n++;
            @(negedge r_clk);
        end
    endtask

    task automatic push_word(input logic [W-1:0] data);
        @(negedge w_clk);
        wait_w_ready(1'b1);
        w_trigger = 1'b1;
        w_data    = data;
        @(negedge w_clk);
        w_trigger = 1'b0;
    endtask

    task automatic push_random(input int count);
        repeat (count) push_word(W'($random(seed)));
    endtask

    task automatic pop_word;
        @(negedge r_clk);
        wait_r_ready(1'b1);
        r_trigger = 1'b1;
        @(negedge r_clk);
        r_trigger = 1'b0;
    endtask

    // Pops until r_ready has stayed low long enough for any write to sync
    task automatic drain_fifo;
        int idle;
        int n;
        idle = 0;
        n    = 0;
        while (idle < 8) begin
            @(negedge r_clk);
            r_trigger = r_ready;
            idle      = r_ready ? 0 : idle + 1;
            if (n == 4 * depth) abort_run("the FIFO never drained");
            n++;
        end
        r_trigger = 1'b0;
    endtask

    // Two sync stages, level register, alert register
    task automatic settle_flags;
        repeat (6) @(negedge r_clk);
    endtask

    task automatic write_register(input afifo_reg_pkg::reg_addr_e addr, input int data);
        @(negedge r_clk);
        reg_req.wr    = 1'b1;
        reg_req.addr  = addr;
        reg_req.wdata = 12'(data);
        @(negedge r_clk);
        reg_req.wr    = 1'b0;
    endtask

    task automatic read_register(input afifo_reg_pkg::reg_addr_e addr, output int data);
        @(negedge r_clk);
        reg_req.wr   = 1'b0;
        reg_req.addr = addr;
        @(posedge r_clk);
        data = int'(reg_rsp.rdata);
    endtask

    task automatic check_level(input int thresh);
        int lvl;
        settle_flags();
        read_register(afifo_reg_pkg::reg_level, lvl);
        check_value(lvl, expected_level(wr_count, rd_count), "reg_level");
        check_value(int'(level_alert), int'(expected_level(wr_count, rd_count) < thresh),
                    "level_alert");
    endtask

    // ====================
    // Test sequence
    // ====================
    initial begin : main_seq
        int v;
        int i;
        int start_wr;
        int start_rd;

        seed     = 19;
        wr_count = 0;
        rd_count = 0;
        n_pass   = 0;
        n_fail   = 0;
        rst_      = 1'b0;
        w_trigger = 1'b0;
        r_trigger = 1'b0;
        w_data    = '0;
        reg_req   = '0;
        repeat (4) @(posedge r_clk);
        @(negedge r_clk);
        rst_ = 1'b1;

        begin_test("reset state");
        @(negedge r_clk);
        check_value(int'(w_ready), 1, "w_ready");
        check_value(int'(r_ready), 0, "r_ready");
        check_value(int'(level_alert), 0, "level_alert");
        read_register(afifo_reg_pkg::reg_thresh, v);
        check_value(v, 0, "reg_thresh");
        read_register(afifo_reg_pkg::reg_level, v);
        check_value(v, 0, "reg_level");
        read_register(afifo_reg_pkg::reg_status, v);
        check_value(v, 0, "reg_status");
        end_test();

        begin_test("ordering");
        start_rd = rd_count;
        push_random(40);
        drain_fifo();
        check_value(rd_count - start_rd, 40, "words read back");
        end_test();

        begin_test("full");
        start_wr = wr_count;
        start_rd = rd_count;
        for (i = 0; i < depth + 1; i++) begin   // One write more than fits
            @(negedge w_clk);
            w_trigger = 1'b1;
            w_data    = W'($random(seed));
        end
        @(negedge w_clk);
        w_trigger = 1'b0;
        check_value(wr_count - start_wr, depth, "accepted writes");
        check_value(int'(w_ready), 0, "w_ready when full");
        pop_word();
        @(negedge w_clk);
        wait_w_ready(1'b1);
        drain_fifo();
        check_value(rd_count - start_rd, depth, "words read back");
        end_test();

        begin_test("empty and underrun");
        read_register(afifo_reg_pkg::reg_status, v);
        check_value(v, 0, "reg_status before underrun");
        start_rd = rd_count;
        push_random(3);
        repeat (3) pop_word();
        check_value(int'(r_ready), 0, "r_ready when drained");   // Falls on the last pop
        @(negedge r_clk);
        r_trigger = 1'b1;   // Pop with nothing stored
        @(negedge r_clk);
        r_trigger = 1'b0;
        read_register(afifo_reg_pkg::reg_status, v);
        check_value(v, 1, "reg_status after underrun");
        push_random(5);
        drain_fifo();
        check_value(rd_count - start_rd, 8, "words read back");
        write_register(afifo_reg_pkg::reg_status, 0);
        read_register(afifo_reg_pkg::reg_status, v);
        check_value(v, 0, "reg_status after clear");
        end_test();

        begin_test("threshold");
        write_register(afifo_reg_pkg::reg_thresh, 20);
        read_register(afifo_reg_pkg::reg_thresh, v);
        check_value(v, 20, "reg_thresh");
        check_level(20);
        push_random(19);
        check_level(20);
        push_random(1);     // Level reaches the threshold
        check_level(20);
        push_random(5);
        check_level(20);
        repeat (10) pop_word();
        check_level(20);
        drain_fifo();
        check_level(20);
        push_random(450);   // Write pointer wraps, read pointer does not
        check_level(20);
        drain_fifo();
        write_register(afifo_reg_pkg::reg_thresh, 0);
        end_test();

        begin_test("random interleaving");
        fork
            begin
                repeat (2000) begin
                    @(negedge r_clk);
                    r_trigger = 1'($random(seed));
                end
                r_trigger = 1'b0;
            end
            begin
                repeat (1400) begin
                    @(negedge w_clk);
                    w_trigger = (2'($random(seed)) != 2'd0);   // Writes a bit faster
                    w_data    = W'($random(seed));
                end
                @(negedge w_clk);
                w_trigger = 1'b0;
            end
        join
        drain_fifo();
        check_value(rd_count, wr_count, "total reads against writes");
        check_value(ref_q.size(), 0, "words left in the reference queue");
        end_test();

        $display("checks passed: %0d, checks failed: %0d", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
